// File: include/map_in_defines.svh
//------------------------------------------------------------
// widths, read pipeline options and register map of the
// MAP decoder input stage
// N is limited to 2**MAP_IN_ADDR_W words and must be even
//------------------------------------------------------------

`ifndef MAP_IN_DEFINES_SVH
`define MAP_IN_DEFINES_SVH

// LLR word and RAM address widths
`define MAP_IN_DATA_W       16
`define MAP_IN_ADDR_W       8

// read pipeline options, 0 or 1 each
`define MAP_IN_APIPE        0
`define MAP_IN_DPIPE        0
// enabled cycles from read address to read data
`define MAP_IN_RD_LAT       (1 + `MAP_IN_APIPE + `MAP_IN_DPIPE)

// AXI4-Lite byte address map
`define MAP_IN_AXI_AW       12
// 0 selects LLR word addr[9:2], 1 selects a register
`define MAP_IN_REG_SEL_BIT  10
`define MAP_IN_REG_LEN      12'h400
`define MAP_IN_REG_CTRL     12'h404
`define MAP_IN_REG_STAT     12'h408

`endif

// File: src/map_in_pkg.sv
//------------------------------------------------------------
// shared types of the MAP input stage
// field widths follow map_in_defines.svh
//------------------------------------------------------------
`default_nettype none

`include "map_in_defines.svh"

package map_in_pkg;

  //------------------------------------------------------------
  // data path items
  //------------------------------------------------------------

  // one RAM write, en is a single cycle strobe
  typedef struct packed {
    logic                        en;
    logic [`MAP_IN_ADDR_W-1:0]   addr;
    logic [`MAP_IN_DATA_W-1:0]   data;
  } llr_wr_t;

  // one output item: forward word k, backward word N-1-k
  typedef struct packed {
    logic [`MAP_IN_DATA_W-1:0]   fwd;
    logic [`MAP_IN_DATA_W-1:0]   bwd;
    logic [`MAP_IN_ADDR_W-1:0]   step;
  } llr_pair_t;

  // sweep command, len is one bit wider to hold N = 2**ADDR_W
  typedef struct packed {
    logic                        start;
    logic [`MAP_IN_ADDR_W:0]     len;
  } sweep_cfg_t;

  //------------------------------------------------------------
  // encodings
  //------------------------------------------------------------

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } sweep_state_e;

  // AXI response codes, only the two used here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

// File: src/map_dec_input_ram.sv
//------------------------------------------------------------
// banked LLR RAM, even words in one bank and odd in the other
// the two read addresses must have opposite parity
// write takes 1 cycle, read takes 1 + APIPE + DPIPE
// enabled cycles, all read stages hold while rd_ena is low
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "map_in_defines.svh"

module map_dec_input_ram #(
  parameter int DATA_W = `MAP_IN_DATA_W,
  parameter int ADDR_W = `MAP_IN_ADDR_W,
  parameter bit APIPE  = `MAP_IN_APIPE,
  parameter bit DPIPE  = `MAP_IN_DPIPE
) (
  input  wire logic                 irclk,
  input  map_in_pkg::llr_wr_t       wr,
  input  wire logic                 rd_ena,
  input  wire logic [ADDR_W-1:0]    raddr0,
  input  wire logic [ADDR_W-1:0]    raddr1,
  output logic      [DATA_W-1:0]    rdata0,
  output logic      [DATA_W-1:0]    rdata1
);

  // each bank holds half the words
  localparam int BANK_AW = ADDR_W - 1;

  logic [DATA_W-1:0]  bank_even [2**BANK_AW];
  logic [DATA_W-1:0]  bank_odd  [2**BANK_AW];

  // swap select and bank addresses, before and after the address stage
  logic               sel_c;
  logic [BANK_AW-1:0] even_a_c;
  logic [BANK_AW-1:0] odd_a_c;
  logic               sel_a;
  logic [BANK_AW-1:0] even_a;
  logic [BANK_AW-1:0] odd_a;

  // bank read registers
  logic               sel_q;
  logic [DATA_W-1:0]  even_q;
  logic [DATA_W-1:0]  odd_q;

  //------------------------------------------------------------
  // write port
  //------------------------------------------------------------

  // bit 0 picks the bank, the rest is the word in the bank
  always_ff @(posedge irclk) begin
    if (wr.en) begin
      if (wr.addr[0]) begin
        bank_odd[wr.addr[ADDR_W-1:1]] <= wr.data;
      end else begin
        bank_even[wr.addr[ADDR_W-1:1]] <= wr.data;
      end
    end
  end

  //------------------------------------------------------------
  // read address switch
  //------------------------------------------------------------

  // sel high means port 0 points into the odd bank
  assign sel_c    = raddr0[0];
  assign even_a_c = sel_c ? raddr1[ADDR_W-1:1] : raddr0[ADDR_W-1:1];
  assign odd_a_c  = sel_c ? raddr0[ADDR_W-1:1] : raddr1[ADDR_W-1:1];

  generate
    if (APIPE) begin : g_apipe
      // extra address stage, eases timing into the bank
      always_ff @(posedge irclk) begin
        if (rd_ena) begin
          sel_a  <= sel_c;
          even_a <= even_a_c;
          odd_a  <= odd_a_c;
        end
      end
    end else begin : g_no_apipe
      assign sel_a  = sel_c;
      assign even_a = even_a_c;
      assign odd_a  = odd_a_c;
    end
  endgenerate

  // registered bank read, select travels with the data
  always_ff @(posedge irclk) begin
    if (rd_ena) begin
      sel_q  <= sel_a;
      even_q <= bank_even[even_a];
      odd_q  <= bank_odd[odd_a];
    end
  end

  //------------------------------------------------------------
  // read data switch back to the ports
  //------------------------------------------------------------

  generate
    if (DPIPE) begin : g_dpipe
      always_ff @(posedge irclk) begin
        if (rd_ena) begin
          rdata0 <= sel_q ? odd_q  : even_q;
          rdata1 <= sel_q ? even_q : odd_q;
        end
      end
    end else begin : g_no_dpipe
      assign rdata0 = sel_q ? odd_q  : even_q;
      assign rdata1 = sel_q ? even_q : odd_q;
    end
  endgenerate

  // both ports share one bank otherwise, the sweep must keep N-1 odd
  a_opposite_parity : assert property (
    @(posedge irclk) rd_ena |-> (raddr0[0] != raddr1[0])
  ) else $error("read ports hit the same bank");

endmodule

`default_nettype wire

// File: src/map_in_axil_regs.sv
//------------------------------------------------------------
// AXI4-Lite slave, one write and one read in flight at most
// AW and W are taken together, no wstrb, full words only
// LLR area is write-only, its reads answer SLVERR
// LEN must be even, nonzero and at most 2**MAP_IN_ADDR_W
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "map_in_defines.svh"

module map_in_axil_regs (
  input  wire logic                        irclk,
  input  wire logic                        rst_n,
  // write address and data
  input  wire logic [`MAP_IN_AXI_AW-1:0]   awaddr,
  input  wire logic                        awvalid,
  output logic                             awready,
  input  wire logic [31:0]                 wdata,
  input  wire logic                        wvalid,
  output logic                             wready,
  // write response
  output map_in_pkg::axi_resp_e            bresp,
  output logic                             bvalid,
  input  wire logic                        bready,
  // read address and data
  input  wire logic [`MAP_IN_AXI_AW-1:0]   araddr,
  input  wire logic                        arvalid,
  output logic                             arready,
  output logic      [31:0]                 rdata,
  output map_in_pkg::axi_resp_e            rresp,
  output logic                             rvalid,
  input  wire logic                        rready,
  // RAM and sweep side
  output map_in_pkg::llr_wr_t              wr,
  output map_in_pkg::sweep_cfg_t           cfg,
  input  wire logic                        busy,
  input  wire logic                        done
);

  import map_in_pkg::*;

  localparam int AW      = `MAP_IN_AXI_AW;
  localparam int RAM_AW  = `MAP_IN_ADDR_W;
  localparam int MAX_LEN = 2 ** `MAP_IN_ADDR_W;

  logic                  aw_w_rdy;
  logic                  wr_acc;
  logic                  rd_acc;
  logic [AW-1:0]         wa;
  logic [AW-1:0]         ra;
  logic                  len_ok;
  logic                  rd_hit;
  logic [31:0]           rd_word;

  // registered outputs toward the RAM and the sweep
  logic                  wr_en;
  logic [RAM_AW-1:0]     wr_addr;
  logic [`MAP_IN_DATA_W-1:0] wr_data;
  logic                  start_q;
  logic [RAM_AW:0]       len_q;
  // sticky done, cleared by the next start
  logic                  done_q;

  assign awready = aw_w_rdy;
  assign wready  = aw_w_rdy;
  assign wr_acc  = aw_w_rdy && awvalid && wvalid;
  assign rd_acc  = arready && arvalid;

  // word aligned byte addresses for register decode
  assign wa = {awaddr[AW-1:2], 2'b00};
  assign ra = {araddr[AW-1:2], 2'b00};

  // odd, zero and oversize lengths are refused
  assign len_ok = !wdata[0] && (wdata != '0) && (wdata <= 32'(MAX_LEN));

  assign wr  = '{en: wr_en, addr: wr_addr, data: wr_data};
  assign cfg = '{start: start_q, len: len_q};

  //------------------------------------------------------------
  // write channel
  //------------------------------------------------------------

  always_ff @(posedge irclk or negedge rst_n) begin
    if (!rst_n) begin
      aw_w_rdy <= 1'b0;
      bvalid   <= 1'b0;
      bresp    <= OKAY;
      wr_en    <= 1'b0;
      start_q  <= 1'b0;
      len_q    <= (RAM_AW + 1)'(MAX_LEN);
      done_q   <= 1'b0;
    end else begin
      // one cycle ready pulse once both channels are up and B is free
      aw_w_rdy <= !aw_w_rdy && awvalid && wvalid && !bvalid;
      wr_en    <= 1'b0;
      start_q  <= 1'b0;
      if (done) begin
        done_q <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_acc) begin
        bvalid <= 1'b1;
        bresp  <= OKAY;
        if (!awaddr[`MAP_IN_REG_SEL_BIT]) begin
          // LLR area, RAM write lands with bvalid
          wr_en <= 1'b1;
        end else begin
          case (wa)
            `MAP_IN_REG_LEN: begin
              if (len_ok) begin
                len_q <= wdata[RAM_AW:0];
              end else begin
                bresp <= SLVERR;
              end
            end
            `MAP_IN_REG_CTRL: begin
              // a start still in flight counts as busy
              if (wdata[0]) begin
                if (busy || start_q) begin
                  bresp <= SLVERR;
                end else begin
                  start_q <= 1'b1;
                  done_q  <= 1'b0;
                end
              end
            end
            // STAT is read-only, holes in the map too
            default: bresp <= SLVERR;
          endcase
        end
      end
    end
  end

  // LLR payload, qualified by wr_en
  always_ff @(posedge irclk) begin
    if (wr_acc) begin
      wr_addr <= awaddr[RAM_AW+1:2];
      wr_data <= wdata[`MAP_IN_DATA_W-1:0];
    end
  end

  //------------------------------------------------------------
  // read channel
  //------------------------------------------------------------

  // register read mux, LLR area and holes miss
  always_comb begin
    rd_hit  = 1'b1;
    rd_word = '0;
    if (!araddr[`MAP_IN_REG_SEL_BIT]) begin
      rd_hit = 1'b0;
    end else begin
      case (ra)
        `MAP_IN_REG_LEN:  rd_word = 32'(len_q);
        `MAP_IN_REG_CTRL: rd_word = '0;
        `MAP_IN_REG_STAT: rd_word = {30'd0, done_q, busy};
        default:          rd_hit  = 1'b0;
      endcase
    end
  end

  always_ff @(posedge irclk or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rresp   <= OKAY;
    end else begin
      arready <= !arready && arvalid && !rvalid;
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (rd_acc) begin
        rvalid <= 1'b1;
        rresp  <= rd_hit ? OKAY : SLVERR;
      end
    end
  end

  // data is zero on a miss
  always_ff @(posedge irclk) begin
    if (rd_acc) begin
      rdata <= rd_word;
    end
  end

  // write response holds until the host takes it
  a_bvalid_hold : assert property (
    @(posedge irclk) disable iff (!rst_n) bvalid && !bready |=> bvalid
  ) else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

// File: src/map_in_sweep_ctrl.sv
//------------------------------------------------------------
// sweep address generator, k and N-1-k on every step
// the RAM output register is the output stage, so the
// whole read pipeline stalls with out_ready
// len must be even, the slave checks it
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "map_in_defines.svh"

module map_in_sweep_ctrl #(
  parameter int RD_LAT = `MAP_IN_RD_LAT
) (
  input  wire logic                        irclk,
  input  wire logic                        rst_n,
  input  map_in_pkg::sweep_cfg_t           cfg,
  // RAM read side
  output logic      [`MAP_IN_ADDR_W-1:0]   raddr0,
  output logic      [`MAP_IN_ADDR_W-1:0]   raddr1,
  output logic                             rd_ena,
  input  wire logic [`MAP_IN_DATA_W-1:0]   rdata0,
  input  wire logic [`MAP_IN_DATA_W-1:0]   rdata1,
  // output stream
  output map_in_pkg::llr_pair_t            pair,
  output logic                             out_valid,
  input  wire logic                        out_ready,
  // status
  output logic                             busy,
  output logic                             done
);

  import map_in_pkg::*;

  localparam int AW = `MAP_IN_ADDR_W;

  sweep_state_e      state;
  // forward index and N-1, last stays odd so the ports never share a bank
  logic [AW-1:0]     k;
  logic [AW-1:0]     last;
  logic              issue;

  // valid bits and step tags that ride along with the RAM pipeline
  logic [RD_LAT-1:0] vld;
  logic [AW-1:0]     step_sr [RD_LAT];

  //------------------------------------------------------------
  // read side
  //------------------------------------------------------------

  // advance when the output stage is empty or being emptied
  assign rd_ena = !out_valid || out_ready;
  assign issue  = (state == RUN) && rd_ena;

  assign raddr0 = k;
  assign raddr1 = last - k;

  //------------------------------------------------------------
  // output stage
  //------------------------------------------------------------

  assign out_valid = vld[RD_LAT-1];
  assign pair      = '{fwd: rdata0, bwd: rdata1, step: step_sr[RD_LAT-1]};

  // steps leave in order, so step N-1 is the final transfer
  assign done = (state == DRAIN) && out_valid && out_ready && (pair.step == last);
  assign busy = (state != IDLE);

  //------------------------------------------------------------
  // FSM
  //------------------------------------------------------------

  always_ff @(posedge irclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      k     <= '0;
      last  <= '1;
    end else begin
      case (state)
        IDLE: begin
          // first address goes out the next cycle
          if (cfg.start) begin
            k     <= '0;
            last  <= AW'(cfg.len - 1'b1);
            state <= RUN;
          end
        end
        RUN: begin
          if (rd_ena) begin
            k <= k + 1'b1;
            if (k == last) begin
              state <= DRAIN;
            end
          end
        end
        // wait for the pipeline to empty
        DRAIN: begin
          if (done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // valid shift register, same enable as the RAM stages
  always_ff @(posedge irclk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else if (rd_ena) begin
      vld[0] <= issue;
      for (int i = 1; i < RD_LAT; i++) begin
        vld[i] <= vld[i-1];
      end
    end
  end

  // step tags, meaningful only where vld is set
  always_ff @(posedge irclk) begin
    if (rd_ena) begin
      step_sr[0] <= k;
      for (int i = 1; i < RD_LAT; i++) begin
        step_sr[i] <= step_sr[i-1];
      end
    end
  end

  // odd N would break the bank split in the RAM
  a_len_even : assert property (
    @(posedge irclk) disable iff (!rst_n) cfg.start |-> !cfg.len[0]
  ) else $error("sweep started with odd length");

endmodule

`default_nettype wire

// File: src/map_in_top.sv
//------------------------------------------------------------
// MAP decoder input stage, AXI4-Lite load and pair stream
// single clock, pairs come out in step order
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "map_in_defines.svh"

module map_in_top (
  input  wire logic                        irclk,
  input  wire logic                        rst_n,
  // AXI4-Lite host port
  input  wire logic [`MAP_IN_AXI_AW-1:0]   awaddr,
  input  wire logic                        awvalid,
  output logic                             awready,
  input  wire logic [31:0]                 wdata,
  input  wire logic                        wvalid,
  output logic                             wready,
  output map_in_pkg::axi_resp_e            bresp,
  output logic                             bvalid,
  input  wire logic                        bready,
  input  wire logic [`MAP_IN_AXI_AW-1:0]   araddr,
  input  wire logic                        arvalid,
  output logic                             arready,
  output logic      [31:0]                 rdata,
  output map_in_pkg::axi_resp_e            rresp,
  output logic                             rvalid,
  input  wire logic                        rready,
  // pair stream
  output map_in_pkg::llr_pair_t            pair,
  output logic                             out_valid,
  input  wire logic                        out_ready
);

  import map_in_pkg::*;

  // slave to RAM and sweep
  llr_wr_t                     wr;
  sweep_cfg_t                  cfg;
  logic                        busy;
  logic                        done;

  // sweep to RAM
  logic                        rd_ena;
  logic [`MAP_IN_ADDR_W-1:0]   raddr0;
  logic [`MAP_IN_ADDR_W-1:0]   raddr1;
  logic [`MAP_IN_DATA_W-1:0]   rdata0;
  logic [`MAP_IN_DATA_W-1:0]   rdata1;

  //------------------------------------------------------------
  // host registers
  //------------------------------------------------------------

  map_in_axil_regs u_regs (
    .irclk   (irclk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .wr      (wr),
    .cfg     (cfg),
    .busy    (busy),
    .done    (done)
  );

  //------------------------------------------------------------
  // sweep and RAM
  //------------------------------------------------------------

  map_in_sweep_ctrl u_sweep (
    .irclk     (irclk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .raddr0    (raddr0),
    .raddr1    (raddr1),
    .rd_ena    (rd_ena),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .pair      (pair),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .busy      (busy),
    .done      (done)
  );

  // pipeline options come from the defines header
  map_dec_input_ram u_ram (
    .irclk  (irclk),
    .wr     (wr),
    .rd_ena (rd_ena),
    .raddr0 (raddr0),
    .raddr1 (raddr1),
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

endmodule

`default_nettype wire

// File: tests/map_in_tb.sv
//------------------------------------------------------------
// testbench of the MAP input stage, blocks come from a table
// LLRs and random out_ready come from a 16 bit LFSR
// block lengths must be even and at most 256
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "map_in_defines.svh"

module map_in_tb;

  import map_in_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_BLK    = 5;

  // one table row: length, LLR base value, random ready
  typedef struct packed {
    logic [9:0]  len;
    logic [15:0] base;
    logic        rnd_ready;
  } block_t;

  block_t blocks [NUM_BLK] = '{
    '{len: 10'd8,   base: 16'h0100, rnd_ready: 1'b0},
    '{len: 10'd64,  base: 16'h1234, rnd_ready: 1'b1},
    '{len: 10'd2,   base: 16'h7f00, rnd_ready: 1'b1},
    '{len: 10'd256, base: 16'h8000, rnd_ready: 1'b0},
    '{len: 10'd32,  base: 16'hfff0, rnd_ready: 1'b1}
  };

  logic                        irclk = 1'b0;
  logic                        rst_n;
  logic [`MAP_IN_AXI_AW-1:0]   awaddr;
  logic                        awvalid;
  logic                        awready;
  logic [31:0]                 wdata;
  logic                        wvalid;
  logic                        wready;
  axi_resp_e                   bresp;
  logic                        bvalid;
  logic                        bready;
  logic [`MAP_IN_AXI_AW-1:0]   araddr;
  logic                        arvalid;
  logic                        arready;
  logic [31:0]                 rdata;
  axi_resp_e                   rresp;
  logic                        rvalid;
  logic                        rready;
  llr_pair_t                   pair;
  logic                        out_valid;
  logic                        out_ready;

  // what was written into the LLR area
  logic [15:0]                 model [256];
  logic [15:0]                 lfsr_q = 16'd62607;

  map_in_top dut (
    .irclk     (irclk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .pair      (pair),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #(CLK_PERIOD / 2) irclk = ~irclk;

  //------------------------------------------------------------
  // helpers
  //------------------------------------------------------------

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      val    = {val[30:0], lfsr_q[15]};
      lfsr_q = {lfsr_q[14:0], fb};
    end
    return val;
  endfunction

  // 4 cycles per pair, 8 per LLR write, plus register traffic
  function automatic int timeout_cycles();
    int total;
    total = 200;
    for (int b = 0; b < NUM_BLK; b++) begin
      total += int'(blocks[b].len) * (4 + 8) + 150;
    end
    return total;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at time %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  //------------------------------------------------------------
  // AXI4-Lite driver
  //------------------------------------------------------------

  // inputs change 1 ns after the edge, ready seen here counts at the next edge
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!(awready && wready)) begin
      @(posedge irclk);
      #1;
    end
    // accepted on this edge
    @(posedge irclk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(posedge irclk);
      #1;
    end
    resp = bresp;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) begin
      @(posedge irclk);
      #1;
    end
    @(posedge irclk);
    #1;
    arvalid = 1'b0;
    while (!rvalid) begin
      @(posedge irclk);
      #1;
    end
    data = rdata;
    resp = rresp;
  endtask

  task automatic reg_write_check(input logic [11:0] addr, input logic [31:0] data,
                                 input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check("bresp", 32'(resp), 32'(exp_resp));
  endtask

  task automatic reg_read_check(input logic [11:0] addr, input logic [31:0] exp_data,
                                input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    check("rresp", 32'(resp), 32'(exp_resp));
    check("rdata", data, exp_data);
  endtask

  //------------------------------------------------------------
  // block steps
  //------------------------------------------------------------

  task automatic load_block(input int n, input logic [15:0] base);
    logic [15:0] val;
    for (int i = 0; i < n; i++) begin
      val      = base + 16'(lfsr_bits(16));
      model[i] = val;
      reg_write_check(12'(i * 4), {16'h0000, val}, OKAY);
    end
  endtask

  // refused lengths must leave the good one in place
  task automatic set_length(input int n);
    reg_write_check(`MAP_IN_REG_LEN, 32'(n), OKAY);
    reg_write_check(`MAP_IN_REG_LEN, 32'(n + 1), SLVERR);
    reg_write_check(`MAP_IN_REG_LEN, 32'd0, SLVERR);
    reg_write_check(`MAP_IN_REG_LEN, 32'd258, SLVERR);
    reg_read_check(`MAP_IN_REG_LEN, 32'(n), OKAY);
  endtask

  // pair k carries word k forward and word N-1-k backward
  task automatic collect_pairs(input int n, input logic rnd);
    int got;
    got = 0;
    while (got < n) begin
      @(posedge irclk);
      #1;
      out_ready = rnd ? (lfsr_bits(1) != 32'd0) : 1'b1;
      if (out_valid && out_ready) begin
        check("pair.step", 32'(pair.step), 32'(got));
        check("pair.fwd", 32'(pair.fwd), 32'(model[got]));
        check("pair.bwd", 32'(pair.bwd), 32'(model[n - 1 - got]));
        got++;
      end
    end
    // nothing may follow the last pair
    repeat (4) begin
      @(posedge irclk);
      #1;
      out_ready = 1'b1;
      check("out_valid", 32'(out_valid), 32'd0);
    end
    @(posedge irclk);
    #1;
    out_ready = 1'b0;
  endtask

  // busy set, done cleared by this start, a second start refused
  task automatic probe_mid_sweep();
    reg_read_check(`MAP_IN_REG_STAT, 32'h1, OKAY);
    reg_write_check(`MAP_IN_REG_CTRL, 32'h1, SLVERR);
    reg_read_check(`MAP_IN_REG_STAT, 32'h1, OKAY);
  endtask

  //------------------------------------------------------------
  // main sequence and watchdog
  //------------------------------------------------------------

  initial begin
    int n;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b1;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b1;
    out_ready = 1'b0;
    // falling edge before the first clock clears the sweep state
    rst_n     = 1'b1;
    #1;
    rst_n     = 1'b0;
    repeat (3) @(posedge irclk);
    #1;
    rst_n = 1'b1;

    check("out_valid", 32'(out_valid), 32'd0);
    check("bvalid", 32'(bvalid), 32'd0);
    check("rvalid", 32'(rvalid), 32'd0);
    check("awready", 32'(awready), 32'd0);
    check("wready", 32'(wready), 32'd0);
    check("arready", 32'(arready), 32'd0);

    // idle status, LLR area has no read path
    reg_read_check(`MAP_IN_REG_STAT, 32'h0, OKAY);
    reg_read_check(12'h010, 32'h0, SLVERR);

    for (int b = 0; b < NUM_BLK; b++) begin
      n = int'(blocks[b].len);
      load_block(n, blocks[b].base);
      set_length(n);
      reg_write_check(`MAP_IN_REG_CTRL, 32'h1, OKAY);
      // short blocks finish before a status read returns
      fork
        collect_pairs(n, blocks[b].rnd_ready);
        if (n >= 16) probe_mid_sweep();
      join
      reg_read_check(`MAP_IN_REG_STAT, 32'h2, OKAY);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    int limit;
    limit = timeout_cycles();
    #(limit * CLK_PERIOD);
    $display("timeout after %0d cycles, a handshake or the sweep never finished", limit);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
src/map_in_pkg.sv
src/map_dec_input_ram.sv
src/map_in_axil_regs.sv
src/map_in_sweep_ctrl.sv
src/map_in_top.sv
tests/map_in_tb.sv

// File: Makefile
# Verilator build and run of the MAP input stage testbench
# the run target fails when the simulation ends through $fatal

VERILATOR ?= verilator
TOP       ?= map_in_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
